// ==== design/core_datapath.sv ====
// --------------------------------------
// Integer pipeline top level
// --------------------------------------

`timescale 1ns/10ps

module core_datapath (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_run,
    input  logic               i_imem_we,
    input  rv_pkg::imem_addr_t i_imem_addr,
    input  rv_pkg::instr_t     i_imem_data,
    output logic               o_reg_we_wb,
    output rv_pkg::reg_addr_t  o_rd_addr_wb,
    output rv_pkg::word_t      o_result_wb
);

    import rv_pkg::*;

    // ------------------------------------
    // Stage nets.
    // ------------------------------------

    // Fetch to decode.
    instr_t    s_instr_dec;
    logic      s_valid_dec;

    // Register file reads.
    reg_addr_t s_rs1_addr_dec;
    reg_addr_t s_rs2_addr_dec;
    word_t     s_rs1_data_dec;
    word_t     s_rs2_data_dec;

    // Decode to execute.
    reg_addr_t s_rs1_addr_exec;
    reg_addr_t s_rs2_addr_exec;
    word_t     s_rs1_data_exec;
    word_t     s_rs2_data_exec;
    word_t     s_imm_exec;
    logic      s_use_imm_exec;
    alu_op_t   s_alu_op_exec;
    reg_addr_t s_rd_exec;
    logic      s_we_exec;

    // Write-back.
    logic      s_wb_we;
    reg_addr_t s_wb_rd;
    word_t     s_wb_result;

    fetch_unit u_fetch_unit (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_run       (i_run),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_instr     (s_instr_dec),
        .o_valid     (s_valid_dec)
    );

    reg_file u_reg_file (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rs1_addr (s_rs1_addr_dec),
        .i_rs2_addr (s_rs2_addr_dec),
        .o_rs1_data (s_rs1_data_dec),
        .o_rs2_data (s_rs2_data_dec),
        .i_we       (s_wb_we),
        .i_rd_addr  (s_wb_rd),
        .i_rd_data  (s_wb_result)
    );

    decode_unit u_decode_unit (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_instr       (s_instr_dec),
        .i_valid       (s_valid_dec),
        .o_rs1_addr    (s_rs1_addr_dec),
        .o_rs2_addr    (s_rs2_addr_dec),
        .i_rs1_data    (s_rs1_data_dec),
        .i_rs2_data    (s_rs2_data_dec),
        .o_ex_rs1_addr (s_rs1_addr_exec),
        .o_ex_rs2_addr (s_rs2_addr_exec),
        .o_ex_rs1_data (s_rs1_data_exec),
        .o_ex_rs2_data (s_rs2_data_exec),
        .o_ex_imm      (s_imm_exec),
        .o_ex_use_imm  (s_use_imm_exec),
        .o_ex_alu_op   (s_alu_op_exec),
        .o_ex_rd       (s_rd_exec),
        .o_ex_we       (s_we_exec)
    );

    execute_unit u_execute_unit (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rs1_addr  (s_rs1_addr_exec),
        .i_rs2_addr  (s_rs2_addr_exec),
        .i_rs1_data  (s_rs1_data_exec),
        .i_rs2_data  (s_rs2_data_exec),
        .i_imm       (s_imm_exec),
        .i_use_imm   (s_use_imm_exec),
        .i_alu_op    (s_alu_op_exec),
        .i_rd        (s_rd_exec),
        .i_we        (s_we_exec),
        .o_wb_we     (s_wb_we),
        .o_wb_rd     (s_wb_rd),
        .o_wb_result (s_wb_result)
    );

    // Write-back port.
    assign o_reg_we_wb  = s_wb_we;
    assign o_rd_addr_wb = s_wb_rd;
    assign o_result_wb  = s_wb_result;

endmodule

// ==== design/decode_unit.sv ====
// --------------------------------------
// Decode stage
// --------------------------------------

`timescale 1ns/10ps

module decode_unit (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::instr_t    i_instr,
    input  logic              i_valid,
    output rv_pkg::reg_addr_t o_rs1_addr,
    output rv_pkg::reg_addr_t o_rs2_addr,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    output rv_pkg::reg_addr_t o_ex_rs1_addr,
    output rv_pkg::reg_addr_t o_ex_rs2_addr,
    output rv_pkg::word_t     o_ex_rs1_data,
    output rv_pkg::word_t     o_ex_rs2_data,
    output rv_pkg::word_t     o_ex_imm,
    output logic              o_ex_use_imm,
    output rv_pkg::alu_op_t   o_ex_alu_op,
    output rv_pkg::reg_addr_t o_ex_rd,
    output logic              o_ex_we
);

    import rv_pkg::*;

    logic [6:0] s_opcode;
    logic [2:0] s_funct3;
    reg_addr_t  s_rd;
    reg_addr_t  s_rs1;
    word_t      s_imm;
    alu_op_t    s_alu_op;
    logic       s_use_imm;
    logic       s_known;
    logic       s_we;

    // Instruction fields.
    assign s_opcode = i_instr[6:0];
    assign s_rd     = i_instr[11:7];
    assign s_funct3 = i_instr[14:12];

    // Shared funct3 map for OP and OP-IMM. Only OP has SUB.
    function automatic alu_op_t funct_to_alu(input logic [2:0] funct3,
                                             input logic       alt,
                                             input logic       is_reg);
        case (funct3)
            3'd0:    return (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // ------------------------------------
    // Opcode decode and immediates.
    // ------------------------------------
    always_comb begin
        s_alu_op  = ALU_ADD;
        s_use_imm = 1'b0;
        s_known   = 1'b1;
        s_rs1     = i_instr[19:15];
        // I-type by default.
        s_imm     = {{(XLEN - 12){i_instr[31]}}, i_instr[31:20]};
        case (s_opcode)
            OPCODE_OP: begin
                s_alu_op = funct_to_alu(s_funct3, i_instr[30], 1'b1);
            end
            OPCODE_OP_IMM: begin
                s_alu_op  = funct_to_alu(s_funct3, i_instr[30], 1'b0);
                s_use_imm = 1'b1;
            end
            OPCODE_LUI: begin
                s_alu_op  = ALU_PASS_B;
                s_use_imm = 1'b1;
                s_imm     = {i_instr[31:12], 12'b0};
                // Keep forwarding off operand A.
                s_rs1     = '0;
            end
            default: begin
                s_known = 1'b0;
            end
        endcase
    end

    // Bubbles, unknown opcodes and x0 never write.
    assign s_we = i_valid && s_known && (s_rd != '0);

    assign o_rs1_addr = s_rs1;
    assign o_rs2_addr = i_instr[24:20];

    // ------------------------------------
    // Decode to execute register.
    // ------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ex_we <= 1'b0;
        end else begin
            o_ex_we <= s_we;
        end
    end

    always_ff @(posedge i_clk) begin
        o_ex_rs1_addr <= s_rs1;
        o_ex_rs2_addr <= i_instr[24:20];
        o_ex_rs1_data <= i_rs1_data;
        o_ex_rs2_data <= i_rs2_data;
        o_ex_imm      <= s_imm;
        o_ex_use_imm  <= s_use_imm;
        o_ex_alu_op   <= s_alu_op;
        o_ex_rd       <= s_rd;
    end

endmodule

// ==== design/execute_unit.sv ====
// --------------------------------------
// Execute stage
// --------------------------------------

`timescale 1ns/10ps

module execute_unit (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    input  rv_pkg::word_t     i_rs1_data,
    input  rv_pkg::word_t     i_rs2_data,
    input  rv_pkg::word_t     i_imm,
    input  logic              i_use_imm,
    input  rv_pkg::alu_op_t   i_alu_op,
    input  rv_pkg::reg_addr_t i_rd,
    input  logic              i_we,
    output logic              o_wb_we,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_result
);

    import rv_pkg::*;

    word_t      s_fwd_rs1;
    word_t      s_fwd_rs2;
    word_t      s_op_a;
    word_t      s_op_b;
    logic [4:0] s_shamt;
    word_t      s_result;

    // ------------------------------------
    // Operand selection.
    // ------------------------------------

    // Take the write-back result on an address match.
    assign s_fwd_rs1 = (o_wb_we && (o_wb_rd == i_rs1_addr)) ? o_wb_result : i_rs1_data;
    assign s_fwd_rs2 = (o_wb_we && (o_wb_rd == i_rs2_addr)) ? o_wb_result : i_rs2_data;

    assign s_op_a  = s_fwd_rs1;
    assign s_op_b  = i_use_imm ? i_imm : s_fwd_rs2;
    assign s_shamt = s_op_b[4:0];

    // ------------------------------------
    // ALU.
    // ------------------------------------
    always_comb begin
        case (i_alu_op)
            ALU_ADD:    s_result = s_op_a + s_op_b;
            ALU_SUB:    s_result = s_op_a - s_op_b;
            ALU_AND:    s_result = s_op_a & s_op_b;
            ALU_OR:     s_result = s_op_a | s_op_b;
            ALU_XOR:    s_result = s_op_a ^ s_op_b;
            ALU_SLL:    s_result = s_op_a << s_shamt;
            ALU_SRL:    s_result = s_op_a >> s_shamt;
            ALU_SRA:    s_result = word_t'($signed(s_op_a) >>> s_shamt);
            ALU_SLT:    s_result = word_t'($signed(s_op_a) < $signed(s_op_b));
            ALU_SLTU:   s_result = word_t'(s_op_a < s_op_b);
            ALU_PASS_B: s_result = s_op_b;
            default:    s_result = '0;
        endcase
    end

    // ------------------------------------
    // Execute to write-back register.
    // ------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_we <= 1'b0;
        end else begin
            o_wb_we <= i_we;
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_rd     <= i_rd;
        o_wb_result <= s_result;
    end

endmodule

// ==== design/fetch_unit.sv ====
// --------------------------------------
// Fetch stage
// --------------------------------------

`timescale 1ns/10ps

module fetch_unit (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_run,
    input  logic               i_imem_we,
    input  rv_pkg::imem_addr_t i_imem_addr,
    input  rv_pkg::instr_t     i_imem_data,
    output rv_pkg::instr_t     o_instr,
    output logic               o_valid
);

    import rv_pkg::*;

    instr_t     s_imem [IMEM_DEPTH];
    word_t      s_pc;
    logic       s_pc_valid;
    imem_addr_t s_read_addr;

    // Word address taken from the byte PC.
    assign s_read_addr = s_pc[IMEM_ADDR_W + 1:2];

    // ------------------------------------
    // Program counter.
    // ------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset || !i_run) begin
            s_pc       <= '0;
            s_pc_valid <= 1'b0;
        end else begin
            s_pc_valid <= 1'b1;
            // First run cycle only arms the PC.
            if (s_pc_valid) begin
                s_pc <= s_pc + word_t'(4);
            end
        end
    end

    // ------------------------------------
    // Instruction memory, synchronous read.
    // ------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_imem_we && !i_run) begin
            s_imem[i_imem_addr] <= i_imem_data;
        end
        o_instr <= s_imem[s_read_addr];
    end

    // Bubble whenever the run level drops.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= s_pc_valid && i_run;
        end
    end

endmodule

// ==== design/reg_file.sv ====
// --------------------------------------
// Register file
// --------------------------------------

`timescale 1ns/10ps

module reg_file (
    input  logic              i_clk,
    input  logic              i_reset,
    input  rv_pkg::reg_addr_t i_rs1_addr,
    input  rv_pkg::reg_addr_t i_rs2_addr,
    output rv_pkg::word_t     o_rs1_data,
    output rv_pkg::word_t     o_rs2_data,
    input  logic              i_we,
    input  rv_pkg::reg_addr_t i_rd_addr,
    input  rv_pkg::word_t     i_rd_data
);

    import rv_pkg::*;

    // x0 has no storage.
    word_t s_regs [1:31];

    // Write-first reads, x0 reads as zero.
    assign o_rs1_data = (i_rs1_addr == '0) ? '0 :
                        (i_we && (i_rd_addr == i_rs1_addr)) ? i_rd_data :
                        s_regs[i_rs1_addr];
    assign o_rs2_data = (i_rs2_addr == '0) ? '0 :
                        (i_we && (i_rd_addr == i_rs2_addr)) ? i_rd_data :
                        s_regs[i_rs2_addr];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                s_regs[i] <= '0;
            end
        end else if (i_we && (i_rd_addr != '0)) begin
            s_regs[i_rd_addr] <= i_rd_data;
        end
    end

endmodule

// ==== design/rv_pkg.sv ====
// --------------------------------------
// Integer pipeline shared definitions
// --------------------------------------

package rv_pkg;

    // ------------------------------------
    // Widths.
    // ------------------------------------
    localparam int XLEN        = 32;
    localparam int INSTR_W     = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;

    // ------------------------------------
    // Vector types.
    // ------------------------------------
    typedef logic [XLEN        - 1:0] word_t;
    typedef logic [INSTR_W     - 1:0] instr_t;
    typedef logic [REG_ADDR_W  - 1:0] reg_addr_t;
    typedef logic [IMEM_ADDR_W - 1:0] imem_addr_t;
    typedef logic [3:0]               alu_op_t;

    // ------------------------------------
    // Opcodes of the kept classes.
    // ------------------------------------
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;

    // ------------------------------------
    // ALU operation codes.
    // ------------------------------------
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    // Operand B straight through, for LUI.
    localparam alu_op_t ALU_PASS_B = 4'd10;

endpackage

// ==== sources.f ====
design/rv_pkg.sv
design/fetch_unit.sv
design/reg_file.sv
design/decode_unit.sv
design/execute_unit.sv
design/core_datapath.sv
verification/tb_core_datapath.sv

// ==== verification/tb_core_datapath.sv ====
// --------------------------------------
// Integer pipeline testbench
// --------------------------------------

`timescale 1ns/10ps

module tb_core_datapath;

    import rv_pkg::*;

    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED    = 32'h9e44_afde;

    logic       i_clk;
    logic       i_reset;
    logic       i_run;
    logic       i_imem_we;
    imem_addr_t i_imem_addr;
    instr_t     i_imem_data;
    logic       o_reg_we_wb;
    reg_addr_t  o_rd_addr_wb;
    word_t      o_result_wb;

    // Model state and expected write-backs.
    word_t       model_regs [32];
    instr_t      prog [$];
    reg_addr_t   exp_rd [$];
    word_t       exp_val [$];
    int          exp_idx [$];
    logic [31:0] lfsr_state;
    int          edge_count;
    int          run_start;
    logic        prev_run;
    int          cycle_limit;

    core_datapath u_core_datapath (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_run        (i_run),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_data  (i_imem_data),
        .o_reg_we_wb  (o_reg_we_wb),
        .o_rd_addr_wb (o_rd_addr_wb),
        .o_result_wb  (o_result_wb)
    );

    always #10 i_clk = ~i_clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "Run stopped on error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s got 0x%08h expected 0x%08h",
                                        name, got, expected));
        end
    endtask

    // ------------------------------------
    // Instruction encoders and stimulus.
    // ------------------------------------
    function automatic instr_t encode_reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                             input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic instr_t encode_imm_op(input logic [2:0] f3, input int rd,
                                             input int rs1, input logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic instr_t encode_lui(input int rd, input logic [19:0] imm);
        return {imm, 5'(rd), 7'b0110111};
    endfunction

    // Galois form, taps x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // ------------------------------------
    // Reference model of one instruction.
    // ------------------------------------
    function automatic bit model_exec(input instr_t instr, output reg_addr_t rd,
                                      output word_t value);
        logic [6:0] opcode;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        bit         writes;
        opcode = instr[6:0];
        f3     = instr[14:12];
        rd     = instr[11:7];
        a      = model_regs[instr[19:15]];
        b      = model_regs[instr[24:20]];
        writes = 1'b1;
        value  = '0;
        if (opcode == 7'b0010011) begin
            b = {{20{instr[31]}}, instr[31:20]};
        end
        sh = b[4:0];
        if (opcode == 7'b0110111) begin
            value = {instr[31:12], 12'h000};
        end else if (opcode == 7'b0110011 || opcode == 7'b0010011) begin
            case (f3)
                3'd0: value = (opcode == 7'b0110011 && instr[30]) ? a - b : a + b;
                3'd1: value = a << sh;
                3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: value = (a < b) ? 32'd1 : 32'd0;
                3'd4: value = a ^ b;
                3'd5: begin
                    if (instr[30]) begin
                        value = $signed(a) >>> sh;
                    end else begin
                        value = a >> sh;
                    end
                end
                3'd6: value = a | b;
                default: value = a & b;
            endcase
        end else begin
            writes = 1'b0;
        end
        // x0 is never written.
        if (rd == 5'd0) begin
            writes = 1'b0;
        end
        if (writes) begin
            model_regs[rd] = value;
        end
        return writes;
    endfunction

    // ------------------------------------
    // Write-back monitor and timeout.
    // ------------------------------------
    always @(posedge i_clk) begin
        edge_count = edge_count + 1;
        if (edge_count > cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d cycles.", cycle_limit));
        end else if (i_reset) begin
            if (edge_count > 1) begin
                check_value("o_reg_we_wb", {31'b0, o_reg_we_wb}, 32'd0);
            end
        end else begin
            if (i_run && !prev_run) begin
                run_start = edge_count;
            end
            prev_run = i_run;
            if (o_reg_we_wb && exp_rd.size() == 0) begin
                stop_with_failure("Write-back seen where no write was expected.");
            end else if (o_reg_we_wb) begin
                check_value("o_rd_addr_wb", {27'b0, o_rd_addr_wb}, {27'b0, exp_rd.pop_front()});
                check_value("o_result_wb", o_result_wb, exp_val.pop_front());
                // Word k lands k + 4 edges after the run starts.
                check_value("write-back edge", edge_count, run_start + 4 + exp_idx.pop_front());
            end
        end
    end

    task automatic run_program();
        reg_addr_t rd;
        word_t     value;
        int        len;
        len         = prog.size();
        cycle_limit = cycle_limit + 2 * len + 30;
        for (int k = 0; k < len; k++) begin
            if (model_exec(prog[k], rd, value)) begin
                exp_rd.push_back(rd);
                exp_val.push_back(value);
                exp_idx.push_back(k);
            end
        end
        // Zero pad covers the words fetched past the end.
        for (int k = 0; k < len + 6; k++) begin
            @(negedge i_clk);
            i_imem_we   = 1'b1;
            i_imem_addr = imem_addr_t'(k);
            i_imem_data = (k < len) ? prog[k] : '0;
        end
        @(negedge i_clk);
        i_imem_we = 1'b0;
        i_run     = 1'b1;
        repeat (len + 6) @(negedge i_clk);
        i_run = 1'b0;
        repeat (8) @(negedge i_clk);
        if (exp_rd.size() != 0) begin
            stop_with_failure("Expected write-back never appeared.");
        end
    endtask

    task automatic build_random(input int count);
        logic [1:0] kind;
        logic [2:0] f3;
        logic [6:0] f7;
        int         rd;
        int         rs1;
        int         rs2;
        prog.delete();
        for (int k = 0; k < count; k++) begin
            kind = 2'(random_bits(2));
            f3   = 3'(random_bits(3));
            // Few registers, so dependencies are dense.
            rd   = random_bits(3);
            rs1  = random_bits(3);
            rs2  = random_bits(3);
            f7   = ((f3 == 3'd0 || f3 == 3'd5) && random_bits(1)) ? 7'h20 : 7'h00;
            if (kind == 2'd0) begin
                prog.push_back(encode_reg_op(f7, f3, rd, rs1, rs2));
            end else if (kind == 2'd3) begin
                prog.push_back(encode_lui(rd, 20'(random_bits(20))));
            end else if (f3 == 3'd1 || f3 == 3'd5) begin
                prog.push_back(encode_imm_op(f3, rd, rs1, {f7, 5'(rs2)}));
            end else begin
                prog.push_back(encode_imm_op(f3, rd, rs1, 12'(random_bits(12))));
            end
        end
    endtask

    initial begin
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_run       = 1'b0;
        i_imem_we   = 1'b0;
        i_imem_addr = '0;
        i_imem_data = '0;
        lfsr_state  = LFSR_SEED;
        edge_count  = 0;
        run_start   = 0;
        prev_run    = 1'b0;
        cycle_limit = RESET_CYCLES + 30;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_reset = 1'b0;

        // Register-register operations.
        prog.delete();
        prog.push_back(encode_imm_op(3'd0, 1, 0, 12'd5));
        prog.push_back(encode_imm_op(3'd0, 2, 0, -3));
        prog.push_back(encode_lui(3, 20'h80000));
        prog.push_back(encode_imm_op(3'd0, 4, 0, 12'h7ff));
        prog.push_back(encode_reg_op(7'h00, 3'd0, 5, 1, 2));
        prog.push_back(encode_reg_op(7'h20, 3'd0, 6, 1, 4));
        prog.push_back(encode_reg_op(7'h20, 3'd0, 7, 0, 1));
        prog.push_back(encode_reg_op(7'h00, 3'd7, 8, 2, 4));
        prog.push_back(encode_reg_op(7'h00, 3'd6, 9, 1, 3));
        prog.push_back(encode_reg_op(7'h00, 3'd4, 10, 2, 4));
        prog.push_back(encode_reg_op(7'h00, 3'd1, 11, 2, 1));
        prog.push_back(encode_reg_op(7'h00, 3'd5, 12, 3, 1));
        prog.push_back(encode_reg_op(7'h20, 3'd5, 13, 3, 1));
        prog.push_back(encode_reg_op(7'h20, 3'd5, 14, 2, 1));
        prog.push_back(encode_reg_op(7'h00, 3'd2, 15, 2, 1));
        prog.push_back(encode_reg_op(7'h00, 3'd3, 16, 2, 1));
        prog.push_back(encode_reg_op(7'h00, 3'd2, 17, 3, 4));
        prog.push_back(encode_reg_op(7'h00, 3'd3, 18, 3, 4));
        run_program();

        // Immediate operations and LUI.
        prog.delete();
        prog.push_back(encode_imm_op(3'd0, 1, 0, -100));
        prog.push_back(encode_imm_op(3'd7, 2, 1, 12'h0f0));
        prog.push_back(encode_imm_op(3'd6, 3, 1, -256));
        prog.push_back(encode_imm_op(3'd4, 4, 1, -1));
        prog.push_back(encode_imm_op(3'd2, 5, 1, -99));
        prog.push_back(encode_imm_op(3'd2, 6, 1, -101));
        prog.push_back(encode_imm_op(3'd3, 7, 1, -1));
        prog.push_back(encode_imm_op(3'd3, 8, 0, -1));
        prog.push_back(encode_imm_op(3'd1, 9, 1, 12'h004));
        prog.push_back(encode_imm_op(3'd5, 10, 1, 12'h01c));
        prog.push_back(encode_imm_op(3'd5, 11, 1, 12'h403));
        prog.push_back(encode_lui(12, 20'habcde));
        prog.push_back(encode_lui(13, 20'hfffff));
        prog.push_back(encode_imm_op(3'd0, 14, 13, -1));
        run_program();

        // Dependency chains at distances one to three.
        prog.delete();
        prog.push_back(encode_imm_op(3'd0, 1, 0, 12'd7));
        prog.push_back(encode_imm_op(3'd0, 1, 1, 12'd3));
        prog.push_back(encode_reg_op(7'h00, 3'd0, 2, 1, 1));
        prog.push_back(encode_reg_op(7'h00, 3'd1, 3, 1, 2));
        prog.push_back(encode_reg_op(7'h00, 3'd6, 4, 3, 1));
        prog.push_back(encode_reg_op(7'h20, 3'd0, 5, 2, 4));
        prog.push_back(encode_imm_op(3'd4, 5, 5, -1));
        prog.push_back(encode_reg_op(7'h00, 3'd3, 6, 5, 4));
        prog.push_back(encode_reg_op(7'h00, 3'd0, 7, 6, 5));
        run_program();

        // x0 targets, x0 sources and unsupported words.
        prog.delete();
        prog.push_back(encode_imm_op(3'd0, 0, 0, 12'd123));
        prog.push_back(encode_imm_op(3'd0, 1, 0, 12'd55));
        prog.push_back(32'h0000_0000);
        prog.push_back(encode_reg_op(7'h00, 3'd0, 0, 1, 1));
        prog.push_back(encode_imm_op(3'd0, 2, 0, -7));
        prog.push_back(32'hffff_ffff);
        prog.push_back(32'h0000_2083);
        prog.push_back(encode_reg_op(7'h00, 3'd0, 3, 1, 2));
        prog.push_back(encode_lui(0, 20'h12345));
        prog.push_back(encode_reg_op(7'h00, 3'd0, 4, 0, 3));
        prog.push_back(encode_reg_op(7'h00, 3'd6, 5, 0, 0));
        run_program();

        for (int p = 0; p < 3; p++) begin
            build_random(40);
            run_program();
        end

        @(negedge i_clk);
        if (exp_rd.size() != 0) begin
            stop_with_failure("Expected write-back left unseen at the end.");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule
